//--- design/fir_pkg.sv
/*
 * widths, tap count, AXI-Lite register map and shared types
 * for the FIR filter
 */
package fir_pkg;

    ////////////////////
    // widths and sizes
    localparam int DATA_WIDTH    = 32;
    localparam int ADDR_WIDTH    = 12;
    localparam int NUM_TAPS      = 11;
    localparam int TAP_IDX_WIDTH = 4;

    ////////////////////
    // shared types
    typedef logic [DATA_WIDTH-1:0]    data_t;
    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [TAP_IDX_WIDTH-1:0] tap_idx_t;

    ////////////////////
    // register map
    localparam addr_t REG_AP_CTRL  = 12'h000;
    // tap i lives at REG_TAP_BASE + 4*i
    localparam addr_t REG_TAP_BASE = 12'h040;

    // control word bits
    localparam int AP_START_BIT = 0;
    localparam int AP_DONE_BIT  = 1;
    localparam int AP_IDLE_BIT  = 2;

    // tap readback while a run is active
    localparam data_t READ_BLOCKED = '1;

endpackage

//--- design/fir_ram.sv
/*
 * simple dual-port RAM, one write port and one registered read port
 */
`timescale 1ns/1ps

module fir_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 11
) (
    input  logic              axis_clk,
    input  logic              we,
    input  fir_pkg::tap_idx_t waddr,
    input  logic [WIDTH-1:0]  wdata,
    input  fir_pkg::tap_idx_t raddr,
    output logic [WIDTH-1:0]  rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // out of range writes are dropped
    always_ff @(posedge axis_clk) begin
        if (we && (int'(waddr) < DEPTH)) begin
            mem[waddr] <= wdata;
        end
        // read data one cycle after the address
        rdata <= mem[raddr];
    end

endmodule

//--- design/fir_axil_regs.sv
/*
 * AXI-Lite slave with control register (start, done, idle),
 * tap address decode and tap RAM read port steering
 */
`timescale 1ns/1ps

module fir_axil_regs (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    // write address and data channels
    input  logic              awvalid,
    output logic              awready,
    input  fir_pkg::addr_t    awaddr,
    input  logic              wvalid,
    output logic              wready,
    input  fir_pkg::data_t    wdata,
    // read address and data channels
    input  logic              arvalid,
    output logic              arready,
    input  fir_pkg::addr_t    araddr,
    output logic              rvalid,
    input  logic              rready,
    output fir_pkg::data_t    rdata,
    // engine handshake
    output logic              run_start,
    input  logic              run_finish,
    // tap RAM
    input  fir_pkg::tap_idx_t eng_tap_raddr,
    input  fir_pkg::data_t    tap_rdata,
    output logic              tap_we,
    output fir_pkg::tap_idx_t tap_waddr,
    output fir_pkg::data_t    tap_wdata,
    output fir_pkg::tap_idx_t tap_raddr
);

    import fir_pkg::*;

    // first byte address past the tap area
    localparam addr_t TAP_END = addr_t'(REG_TAP_BASE + 4 * NUM_TAPS);

    function automatic logic is_tap(addr_t addr);
        return (addr >= REG_TAP_BASE) && (addr < TAP_END);
    endfunction

    // byte address to word index
    function automatic tap_idx_t tap_index(addr_t addr);
        addr_t offset;
        offset = addr - REG_TAP_BASE;
        return offset[TAP_IDX_WIDTH+1:2];
    endfunction

    logic  ap_start;
    logic  ap_done;
    logic  ap_idle;
    logic  wr_fire;
    logic  start_fire;
    logic  rd_accept;
    logic  rd_fetch;
    logic  ctrl_read;
    addr_t rd_addr;
    data_t ctrl_word;
    data_t rd_word;

    ////////////////////
    // write channel

    // address and data taken together, once per transfer
    assign wr_fire    = awvalid && wvalid && !awready && !wready;
    assign start_fire = wr_fire && (awaddr == REG_AP_CTRL) && ap_idle
                        && wdata[AP_START_BIT];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
        end else begin
            awready <= wr_fire;
            wready  <= wr_fire;
        end
    end

    // coefficients only change while idle
    assign tap_we    = wr_fire && is_tap(awaddr) && ap_idle;
    assign tap_waddr = tap_index(awaddr);
    assign tap_wdata = wdata;

    ////////////////////
    // control register

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            ap_idle  <= 1'b1;
        end else begin
            ap_start <= 1'b0;
            if (start_fire) begin
                ap_start <= 1'b1;
                ap_done  <= 1'b0;
                ap_idle  <= 1'b0;
            end else if (run_finish) begin
                ap_done <= 1'b1;
                ap_idle <= 1'b1;
            end else if (ctrl_read) begin
                // read to clear
                ap_done <= 1'b0;
            end
        end
    end

    // start is a single cycle wide, so it doubles as the engine pulse
    assign run_start = ap_start;

    always_comb begin
        ctrl_word               = '0;
        ctrl_word[AP_START_BIT] = ap_start;
        ctrl_word[AP_DONE_BIT]  = ap_done;
        ctrl_word[AP_IDLE_BIT]  = ap_idle;
    end

    ////////////////////
    // read channel

    // one read in flight, none taken while rvalid is up
    assign rd_accept = arvalid && !arready && !rd_fetch && !rvalid;
    assign ctrl_read = rd_fetch && (rd_addr == REG_AP_CTRL);

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            arready  <= 1'b0;
            rd_fetch <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            arready  <= rd_accept;
            // RAM address goes out while arready is high
            rd_fetch <= arready;
            if (rd_fetch) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        if (rd_addr == REG_AP_CTRL) begin
            rd_word = ctrl_word;
        end else if (!is_tap(rd_addr)) begin
            rd_word = '0;
        end else if (!ap_idle) begin
            rd_word = READ_BLOCKED;
        end else begin
            rd_word = tap_rdata;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rd_accept) begin
            rd_addr <= araddr;
        end
        if (rd_fetch) begin
            rdata <= rd_word;
        end
    end

    // engine owns the tap read port during a run
    assign tap_raddr = ap_idle ? tap_index(rd_addr) : eng_tap_raddr;

endmodule

//--- design/fir_engine.sv
/*
 * stream handshakes, circular sample history and the
 * two-stage multiply-accumulate sequencer
 */
`timescale 1ns/1ps

module fir_engine (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              run_start,
    output logic              run_finish,
    // stream in
    input  logic              ss_tvalid,
    output logic              ss_tready,
    input  fir_pkg::data_t    ss_tdata,
    input  logic              ss_tlast,
    // stream out
    output logic              sm_tvalid,
    input  logic              sm_tready,
    output fir_pkg::data_t    sm_tdata,
    output logic              sm_tlast,
    // tap RAM read port
    output fir_pkg::tap_idx_t eng_tap_raddr,
    input  fir_pkg::data_t    tap_rdata,
    // data RAM
    output logic              data_we,
    output fir_pkg::tap_idx_t data_waddr,
    output fir_pkg::data_t    data_wdata,
    output fir_pkg::tap_idx_t data_raddr,
    input  fir_pkg::data_t    data_rdata
);

    import fir_pkg::*;

    localparam tap_idx_t LAST_TAP   = tap_idx_t'(NUM_TAPS - 1);
    localparam tap_idx_t HIST_DEPTH = tap_idx_t'(NUM_TAPS);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT,
        S_WRITE,
        S_READ,
        S_DRAIN,
        S_HOLD
    } state_t;

    state_t   state;
    tap_idx_t tap_idx;
    tap_idx_t wptr;
    tap_idx_t hist_cnt;
    logic     last_q;
    logic     rd_en_q;
    logic     rd_live_q;
    logic     ss_fire;
    logic     sm_fire;
    data_t    sample_q;
    data_t    product;
    data_t    acc;

    assign ss_tready  = (state == S_WAIT);
    assign sm_tvalid  = (state == S_HOLD);
    assign sm_tdata   = acc;
    assign sm_tlast   = sm_tvalid && last_q;
    assign ss_fire    = ss_tvalid && ss_tready;
    assign sm_fire    = sm_tvalid && sm_tready;
    assign run_finish = sm_fire && last_q;

    ////////////////////
    // sequencer

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= S_IDLE;
        end else if (run_start) begin
            state <= S_WAIT;
        end else begin
            case (state)
                S_WAIT: begin
                    if (ss_fire) begin
                        state <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    state <= S_READ;
                end
                S_READ: begin
                    if (tap_idx == LAST_TAP) begin
                        state <= S_DRAIN;
                    end
                end
                // last product still in the MAC stage
                S_DRAIN: begin
                    state <= S_HOLD;
                end
                S_HOLD: begin
                    if (sm_fire) begin
                        state <= last_q ? S_IDLE : S_WAIT;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // tap index, history pointer and fill count
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            tap_idx  <= '0;
            wptr     <= '0;
            hist_cnt <= '0;
            last_q   <= 1'b0;
        end else if (run_start) begin
            tap_idx  <= '0;
            wptr     <= '0;
            hist_cnt <= '0;
            last_q   <= 1'b0;
        end else begin
            if (ss_fire) begin
                tap_idx <= '0;
                last_q  <= ss_tlast;
            end
            if (state == S_READ) begin
                tap_idx <= tap_idx + 1'b1;
            end
            // saturates once the history is full
            if ((state == S_WRITE) && (hist_cnt != HIST_DEPTH)) begin
                hist_cnt <= hist_cnt + 1'b1;
            end
            if (state == S_DRAIN) begin
                wptr <= (wptr == LAST_TAP) ? '0 : wptr + 1'b1;
            end
        end
    end

    ////////////////////
    // history RAM access

    assign data_we       = (state == S_WRITE);
    assign data_waddr    = wptr;
    assign data_wdata    = sample_q;
    assign eng_tap_raddr = tap_idx;

    // x[n-k] sits k slots behind the write pointer, wrapping at NUM_TAPS
    always_comb begin
        if (wptr >= tap_idx) begin
            data_raddr = wptr - tap_idx;
        end else begin
            data_raddr = wptr + HIST_DEPTH - tap_idx;
        end
    end

    ////////////////////
    // MAC pipeline

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            rd_en_q   <= 1'b0;
            rd_live_q <= 1'b0;
        end else begin
            rd_en_q   <= (state == S_READ);
            // slots not written since start count as zero
            rd_live_q <= (tap_idx < hist_cnt);
        end
    end

    // 32-bit product, upper half dropped
    assign product = tap_rdata * data_rdata;

    always_ff @(posedge axis_clk) begin
        if (ss_fire) begin
            sample_q <= ss_tdata;
            acc      <= '0;
        end else if (rd_en_q) begin
            acc <= acc + (rd_live_q ? product : '0);
        end
    end

endmodule

//--- design/fir_top.sv
/*
 * FIR filter top level: register block, engine, tap and data RAMs
 */
`timescale 1ns/1ps

module fir_top (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    // AXI-Lite
    input  logic           awvalid,
    output logic           awready,
    input  fir_pkg::addr_t awaddr,
    input  logic           wvalid,
    output logic           wready,
    input  fir_pkg::data_t wdata,
    input  logic           arvalid,
    output logic           arready,
    input  fir_pkg::addr_t araddr,
    output logic           rvalid,
    input  logic           rready,
    output fir_pkg::data_t rdata,
    // AXI-Stream in
    input  logic           ss_tvalid,
    output logic           ss_tready,
    input  fir_pkg::data_t ss_tdata,
    input  logic           ss_tlast,
    // AXI-Stream out
    output logic           sm_tvalid,
    input  logic           sm_tready,
    output fir_pkg::data_t sm_tdata,
    output logic           sm_tlast
);

    import fir_pkg::*;

    logic     run_start;
    logic     run_finish;
    tap_idx_t eng_tap_raddr;
    logic     tap_we;
    tap_idx_t tap_waddr;
    data_t    tap_wdata;
    tap_idx_t tap_raddr;
    data_t    tap_rdata;
    logic     data_we;
    tap_idx_t data_waddr;
    data_t    data_wdata;
    tap_idx_t data_raddr;
    data_t    data_rdata;

    fir_axil_regs u_regs (
        .axis_clk      (axis_clk),
        .axis_rst_n    (axis_rst_n),
        .awvalid       (awvalid),
        .awready       (awready),
        .awaddr        (awaddr),
        .wvalid        (wvalid),
        .wready        (wready),
        .wdata         (wdata),
        .arvalid       (arvalid),
        .arready       (arready),
        .araddr        (araddr),
        .rvalid        (rvalid),
        .rready        (rready),
        .rdata         (rdata),
        .run_start     (run_start),
        .run_finish    (run_finish),
        .eng_tap_raddr (eng_tap_raddr),
        .tap_rdata     (tap_rdata),
        .tap_we        (tap_we),
        .tap_waddr     (tap_waddr),
        .tap_wdata     (tap_wdata),
        .tap_raddr     (tap_raddr)
    );

    fir_engine u_engine (
        .axis_clk      (axis_clk),
        .axis_rst_n    (axis_rst_n),
        .run_start     (run_start),
        .run_finish    (run_finish),
        .ss_tvalid     (ss_tvalid),
        .ss_tready     (ss_tready),
        .ss_tdata      (ss_tdata),
        .ss_tlast      (ss_tlast),
        .sm_tvalid     (sm_tvalid),
        .sm_tready     (sm_tready),
        .sm_tdata      (sm_tdata),
        .sm_tlast      (sm_tlast),
        .eng_tap_raddr (eng_tap_raddr),
        .tap_rdata     (tap_rdata),
        .data_we       (data_we),
        .data_waddr    (data_waddr),
        .data_wdata    (data_wdata),
        .data_raddr    (data_raddr),
        .data_rdata    (data_rdata)
    );

    // coefficients, written over AXI-Lite only
    fir_ram #(
        .WIDTH (DATA_WIDTH),
        .DEPTH (NUM_TAPS)
    ) tap_ram (
        .axis_clk (axis_clk),
        .we       (tap_we),
        .waddr    (tap_waddr),
        .wdata    (tap_wdata),
        .raddr    (tap_raddr),
        .rdata    (tap_rdata)
    );

    // circular sample history
    fir_ram #(
        .WIDTH (DATA_WIDTH),
        .DEPTH (NUM_TAPS)
    ) data_ram (
        .axis_clk (axis_clk),
        .we       (data_we),
        .waddr    (data_waddr),
        .wdata    (data_wdata),
        .raddr    (data_raddr),
        .rdata    (data_rdata)
    );

endmodule

//--- verification/fir_tasks.svh
/*
 * compare tasks, AXI-Lite and AXI-Stream driver tasks,
 * and the directed tests for the FIR filter
 */

////////////////////
// compare tasks

task automatic check_data(input string name, input data_t actual, input data_t expected);
    check_count++;
    if (actual !== expected) begin
        err_count++;
        $display("ERROR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
    check_count++;
    if (actual !== expected) begin
        err_count++;
        $display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
endtask

task automatic report_test(input string name, input int err_start, input int chk_start);
    $display("%-16s %0d checks, %0d errors", name, check_count - chk_start,
             err_count - err_start);
endtask

function automatic addr_t tap_addr(int idx);
    return addr_t'(REG_TAP_BASE + 4 * idx);
endfunction

////////////////////
// bus drivers called on a falling edge

task automatic axil_write(input addr_t addr, input data_t data);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!(awready && wready)) @(negedge axis_clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge axis_clk);
endtask

task automatic axil_read(input addr_t addr, output data_t data);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;
    while (!arready) @(negedge axis_clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge axis_clk);
    data   = rdata;
    rready = 1'b1;
    @(negedge axis_clk);
    rready = 1'b0;
endtask

task automatic send_sample(input data_t data, input logic last);
    ss_tdata  = data;
    ss_tlast  = last;
    ss_tvalid = 1'b1;
    while (!ss_tready) @(negedge axis_clk);
    // transfer happens on the rising edge in between
    @(negedge axis_clk);
    ss_tvalid = 1'b0;
    ss_tlast  = 1'b0;
endtask

// result held for stall cycles with sm_tready low once it is up
task automatic recv_result(input int stall, input data_t expected, input logic last);
    sm_tready = (stall == 0);
    while (!sm_tvalid) begin
        check_bit("ss_tready", ss_tready, 1'b0);
        @(negedge axis_clk);
    end
    check_data("sm_tdata", sm_tdata, expected);
    check_bit("sm_tlast", sm_tlast, last);
    repeat (stall) begin
        @(negedge axis_clk);
        check_bit("sm_tvalid", sm_tvalid, 1'b1);
        check_data("sm_tdata", sm_tdata, expected);
        check_bit("sm_tlast", sm_tlast, last);
        check_bit("ss_tready", ss_tready, 1'b0);
    end
    sm_tready = 1'b1;
    @(negedge axis_clk);
    check_bit("sm_tvalid", sm_tvalid, 1'b0);
endtask

////////////////////
// run control

task automatic start_run();
    samples.delete();
    axil_write(REG_AP_CTRL, data_t'(1) << AP_START_BIT);
endtask

task automatic stream_run(input int n, input int max_stall);
    data_t x;
    int    stall;
    int    i;
    for (i = 0; i < n; i++) begin
        x = $urandom;
        samples.push_back(x);
        stall = (max_stall > 0) ? int'($urandom_range(max_stall, 0)) : 0;
        send_sample(x, i == n - 1);
        recv_result(stall, model_output(samples.size() - 1), i == n - 1);
    end
endtask

// done and idle set by the last output
// first read clears done
task automatic check_finished();
    data_t word;
    axil_read(REG_AP_CTRL, word);
    check_bit("ap_done", word[AP_DONE_BIT], 1'b1);
    check_bit("ap_idle", word[AP_IDLE_BIT], 1'b1);
    axil_read(REG_AP_CTRL, word);
    check_bit("ap_done", word[AP_DONE_BIT], 1'b0);
    check_bit("ap_idle", word[AP_IDLE_BIT], 1'b1);
endtask

////////////////////
// directed tests

task automatic test_reset_state();
    int    e0;
    int    c0;
    data_t word;
    e0 = err_count;
    c0 = check_count;
    repeat (4) begin
        check_bit("ss_tready", ss_tready, 1'b0);
        check_bit("sm_tvalid", sm_tvalid, 1'b0);
        @(negedge axis_clk);
    end
    axil_read(REG_AP_CTRL, word);
    check_bit("ap_start", word[AP_START_BIT], 1'b0);
    check_bit("ap_done", word[AP_DONE_BIT], 1'b0);
    check_bit("ap_idle", word[AP_IDLE_BIT], 1'b1);
    check_bit("ss_tready", ss_tready, 1'b0);
    check_bit("sm_tvalid", sm_tvalid, 1'b0);
    report_test("reset_state", e0, c0);
endtask

task automatic test_tap_program();
    int    e0;
    int    c0;
    int    i;
    data_t word;
    e0 = err_count;
    c0 = check_count;
    for (i = 0; i < NUM_TAPS; i++) begin
        taps[i] = $urandom;
        axil_write(tap_addr(i), taps[i]);
    end
    for (i = 0; i < NUM_TAPS; i++) begin
        axil_read(tap_addr(i), word);
        check_data($sformatf("tap[%0d]", i), word, taps[i]);
    end
    report_test("tap_program", e0, c0);
endtask

task automatic test_filter();
    int e0;
    int c0;
    e0 = err_count;
    c0 = check_count;
    start_run();
    stream_run(FILTER_SAMPLES, 0);
    check_finished();
    report_test("filter", e0, c0);
endtask

task automatic test_backpressure();
    int e0;
    int c0;
    e0 = err_count;
    c0 = check_count;
    start_run();
    stream_run(BP_SAMPLES, MAX_STALL);
    check_finished();
    report_test("backpressure", e0, c0);
endtask

task automatic test_busy_restart();
    int    e0;
    int    c0;
    data_t word;
    e0 = err_count;
    c0 = check_count;
    start_run();
    // tap port belongs to the engine now
    axil_read(tap_addr(3), word);
    check_data("rdata", word, READ_BLOCKED);
    axil_write(tap_addr(0), ~taps[0]);
    stream_run(BUSY_SAMPLES, 0);
    check_finished();
    axil_read(tap_addr(0), word);
    check_data("tap[0]", word, taps[0]);
    // second run sees an empty history again
    start_run();
    stream_run(BUSY_SAMPLES, 0);
    check_finished();
    report_test("busy_restart", e0, c0);
endtask

//--- verification/tb_fir_top.sv
/*
 * FIR filter testbench: clock, reset, DUT instance, watchdog,
 * reference model and test sequence
 */
`timescale 1ns/1ps

module tb_fir_top;

    import fir_pkg::*;

    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 16;
    localparam int FILTER_SAMPLES = 20;
    localparam int BP_SAMPLES     = 12;
    localparam int BUSY_SAMPLES   = 8;
    localparam int MAX_STALL      = 6;
    localparam int TOTAL_SAMPLES  = FILTER_SAMPLES + BP_SAMPLES + 2 * BUSY_SAMPLES;
    // filter latency and worst stall per sample, plus register traffic
    localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * (NUM_TAPS + 2 + MAX_STALL + 4) + 2000;

    logic  axis_clk;
    logic  axis_rst_n;
    logic  awvalid;
    logic  awready;
    addr_t awaddr;
    logic  wvalid;
    logic  wready;
    data_t wdata;
    logic  arvalid;
    logic  arready;
    addr_t araddr;
    logic  rvalid;
    logic  rready;
    data_t rdata;
    logic  ss_tvalid;
    logic  ss_tready;
    data_t ss_tdata;
    logic  ss_tlast;
    logic  sm_tvalid;
    logic  sm_tready;
    data_t sm_tdata;
    logic  sm_tlast;

    // coefficients as programmed, and the samples of the current run
    data_t taps [NUM_TAPS];
    data_t samples [$];
    int    err_count;
    int    check_count;

    fir_top uut (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    always #(CLK_PERIOD / 2) axis_clk = ~axis_clk;

    ////////////////////
    // reference model

    // y[n] = sum of tap[k] * x[n-k], 32-bit wrap, x before the run is zero
    function automatic data_t model_output(int n);
        data_t acc;
        int    k;
        acc = '0;
        for (k = 0; k < NUM_TAPS; k++) begin
            if (n - k >= 0) begin
                acc = acc + taps[k] * samples[n - k];
            end
        end
        return acc;
    endfunction

    `include "fir_tasks.svh"

    ////////////////////
    // watchdog

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, a handshake never completed",
                 WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    ////////////////////
    // test sequence

    initial begin
        void'($urandom(6));
        err_count   = 0;
        check_count = 0;
        axis_clk    = 1'b0;
        axis_rst_n  = 1'b0;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b0;
        ss_tvalid   = 1'b0;
        ss_tdata    = '0;
        ss_tlast    = 1'b0;
        sm_tready   = 1'b0;
        repeat (RESET_CYCLES) @(negedge axis_clk);
        axis_rst_n = 1'b1;
        @(negedge axis_clk);

        test_reset_state();
        test_tap_program();
        test_filter();
        test_backpressure();
        test_busy_restart();

        repeat (4) @(negedge axis_clk);
        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- fir_top.f
+incdir+verification
design/fir_pkg.sv
design/fir_ram.sv
design/fir_axil_regs.sv
design/fir_engine.sv
design/fir_top.sv
verification/tb_fir_top.sv

//--- Makefile
# Verilator build and run for the FIR filter testbench

SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP      := tb_fir_top
FILELIST := fir_top.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
